//--- all.f
hdl/gt_bringup_pkg.sv
hdl/reset_request.sv
hdl/gt_reset_stage.sv
hdl/gt_reset_chain.sv
hdl/tx_word_mux.sv
hdl/gt_bringup_top.sv
bench/gt_bringup_tb.sv

//--- bench/gt_bringup_tb.sv
`timescale 1ns/1ps

module gt_bringup_tb
	import gt_bringup_pkg::*;
();

	localparam int POR_DELAY = 100;
	localparam int RESET_LEN = 10;
	localparam int PH_IDLE = 0; // model stage phases
	localparam int PH_WAIT = 1;
	localparam int PH_RST  = 2;
	localparam int PH_DONE = 3;
	localparam int SIG_PLL  = 0; // selectors for probe_level
	localparam int SIG_TXRX = 1;
	localparam int SIG_LINK = 2;

	logic       clk200;
	logic       rst_n;
	logic       soft_reset;
	logic       sfp_los;
	gt_status_t gt_status;
	word32_t    tx_payload;
	gt_ctrl_t   gt_ctrl;
	word32_t    tx_data;
	charisk_t   tx_charisk;
	logic       link_up;

	integer seed = 32'hdedf_d67b;
	logic   hold_qpll; // xcvr keeps qpll_lock low after a pll reset
	logic   model_live = 1'b0; // model has been through reset
	logic   win_q = 1'b0; // model align window, one edge late for the xcvr

	int         m_rel_cnt; // edges since rst_n release, saturates
	logic [2:0] m_los_hist; // sfp_los samples, newest in bit 0
	logic       m_hw; // merged request
	int         m_phase [4]; // pll, chan pass 1, chan pass 2, align
	int         m_left [4]; // reset cycles still to go
	logic       m_strobe [4];
	logic       m_second;
	logic       m_second_d;
	logic       m_link;
	word32_t    m_tx_data;
	charisk_t   m_tx_k;

	gt_bringup_top #(.POR_DELAY(POR_DELAY), .RESET_LEN(RESET_LEN)) uut (
		.clk200     (clk200),
		.rst_n      (rst_n),
		.soft_reset (soft_reset),
		.sfp_los    (sfp_los),
		.gt_status  (gt_status),
		.tx_payload (tx_payload),
		.gt_ctrl    (gt_ctrl),
		.tx_data    (tx_data),
		.tx_charisk (tx_charisk),
		.link_up    (link_up)
	);

	initial begin
		clk200 = 1'b0;
		forever #20 clk200 = ~clk200; // 40 ns period
	end

	function automatic int rand_between(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff; // keep it positive
		return lo + r % (hi - lo + 1);
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, actual, expected));
		end
	endtask

	function automatic logic probe_level(input int sel);
		case (sel)
			SIG_PLL:  return gt_ctrl.pll_reset;
			SIG_TXRX: return gt_ctrl.txrx_reset;
			default:  return link_up;
		endcase
	endfunction

	// samples on falling edges only
	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		@(negedge clk200);
		while (probe_level(sel) !== level) begin
			if (n >= limit) begin
				stop_on_error($sformatf("timeout after %0d cycles waiting for %s", limit, what));
			end else begin
				n = n + 1;
				@(negedge clk200);
			end
		end
	endtask

	task automatic measure_pulse(input int sel, input int limit, input string what);
		int len;
		len = 0;
		wait_level(sel, 1'b1, limit, {what, " to rise"});
		while (probe_level(sel) === 1'b1) begin
			if (len > 2 * RESET_LEN) begin
				stop_on_error($sformatf("%s stayed high far too long", what));
			end else begin
				len = len + 1;
				@(negedge clk200);
			end
		end
		check_value({what, " length"}, len, RESET_LEN);
	endtask

	// everything after the pll pulse up to link_up
	task automatic complete_bringup();
		measure_pulse(SIG_TXRX, 200, "txrx_reset pass 1");
		measure_pulse(SIG_TXRX, 200, "txrx_reset pass 2");
		wait_level(SIG_LINK, 1'b1, 300, "link_up");
		check_value("byte_aligned at link_up", 32'(gt_status.byte_aligned), 32'd1);
	endtask

	task automatic strobe_soft_reset();
		@(posedge clk200);
		soft_reset <= 1'b1;
		@(posedge clk200);
		soft_reset <= 1'b0;
	endtask

	task automatic drop_los(input int len);
		@(posedge clk200);
		sfp_los <= 1'b1; // fiber goes dark
		repeat (len) @(posedge clk200);
		sfp_los <= 1'b0; // signal back, reconnect
	endtask

	task automatic advance_stage(input int idx, input logic go, input logic rdy,
		input logic fin);
		m_strobe[idx] = 1'b0;
		if (go) begin
			m_phase[idx] = PH_WAIT; // restart from anywhere
		end else begin
			case (m_phase[idx])
				PH_WAIT: begin
					if (rdy) begin
						m_phase[idx] = PH_RST;
						m_left[idx]  = RESET_LEN;
					end
				end
				PH_RST: begin
					if (m_left[idx] == 1) begin
						m_phase[idx] = PH_DONE;
					end else begin
						m_left[idx] = m_left[idx] - 1;
					end
				end
				PH_DONE: begin
					if (fin) begin
						m_phase[idx]  = PH_IDLE;
						m_strobe[idx] = 1'b1;
					end
				end
				default: m_phase[idx] = PH_IDLE;
			endcase
		end
	endtask

	// reference model, next state from pre-edge inputs and model state
	always @(posedge clk200) begin : ref_model
		logic plls_ok;
		logic chan_ok;
		logic txrx_ok;
		logic hw_next;
		logic go [4];
		logic rdy [4];
		logic fin [4];
		int   i;
		if (!rst_n) begin
			m_rel_cnt  = 0;
			m_los_hist = '0;
			m_hw       = 1'b0;
			m_second   = 1'b0;
			m_second_d = 1'b0;
			m_link     = 1'b0;
			m_tx_data  = COMMA_WORD;
			m_tx_k     = COMMA_K;
			for (i = 0; i < 4; i = i + 1) begin
				m_phase[i]  = PH_IDLE;
				m_left[i]   = 0;
				m_strobe[i] = 1'b0;
			end
			model_live = 1'b1;
		end else begin
			plls_ok = gt_status.mmcm_locked & gt_status.qpll_lock & gt_status.cpll_lock
				& ~(gt_status.qpll_refclk_lost | gt_status.cpll_fbclk_lost
				| gt_status.cpll_refclk_lost);
			chan_ok = gt_status.tx_reset_done & gt_status.rx_reset_done & plls_ok;
			txrx_ok = chan_ok & m_second_d;
			if (gt_status.byte_aligned || m_phase[3] == PH_RST) begin
				m_tx_data = tx_payload; // aligned or window open
				m_tx_k    = '0;
			end else begin
				m_tx_data = COMMA_WORD;
				m_tx_k    = COMMA_K;
			end
			if (m_rel_cnt <= POR_DELAY) begin
				m_rel_cnt = m_rel_cnt + 1;
			end
			hw_next = (m_rel_cnt == POR_DELAY) | soft_reset
				| (m_los_hist[2] & ~m_los_hist[1]); // los seen high then low
			m_los_hist = {m_los_hist[1:0], sfp_los};
			go[0]  = m_hw;
			go[1]  = m_strobe[0];
			go[2]  = m_strobe[1];
			go[3]  = m_strobe[2];
			rdy[0] = gt_status.mmcm_locked;
			rdy[1] = plls_ok;
			rdy[2] = plls_ok & m_second;
			rdy[3] = txrx_ok;
			fin[0] = plls_ok;
			fin[1] = txrx_ok;
			fin[2] = txrx_ok;
			fin[3] = gt_status.byte_aligned;
			if (m_hw) begin
				m_link = 1'b0;
			end else if (m_strobe[3]) begin
				m_link = 1'b1;
			end
			m_second_d = m_second;
			if (m_hw) begin
				m_second = 1'b0;
			end else if (chan_ok) begin
				m_second = 1'b1;
			end
			for (i = 0; i < 4; i = i + 1) begin
				advance_stage(i, go[i], rdy[i], fin[i]);
			end
			m_hw = hw_next;
		end
		win_q <= (m_phase[3] == PH_RST);
	end

	// outputs settle well before the falling edge
	always @(negedge clk200) begin
		if (model_live) begin
			check_value("gt_ctrl.pll_reset", 32'(gt_ctrl.pll_reset), 32'(m_phase[0] == PH_RST));
			check_value("gt_ctrl.txrx_reset", 32'(gt_ctrl.txrx_reset),
				32'(m_phase[1] == PH_RST || m_phase[2] == PH_RST));
			check_value("link_up", 32'(link_up), 32'(m_link));
			check_value("tx_data", tx_data, m_tx_data);
			check_value("tx_charisk", 32'(tx_charisk), 32'(m_tx_k));
		end
	end

	// behavioral transceiver, reacts to the reset lines
	initial begin : xcvr_model
		int   lock_wait;
		int   done_wait;
		int   align_wait;
		logic win_d;
		gt_status = '0;
		gt_status.mmcm_locked = 1'b1; // mmcm always locked here
		lock_wait  = 0;
		done_wait  = 0;
		align_wait = 0;
		win_d      = 1'b0;
		forever begin
			@(posedge clk200);
			if (gt_ctrl.pll_reset) begin
				gt_status.qpll_lock     <= 1'b0;
				gt_status.cpll_lock     <= 1'b0;
				gt_status.tx_reset_done <= 1'b0; // channel is dead too
				gt_status.rx_reset_done <= 1'b0;
				gt_status.byte_aligned  <= 1'b0;
				lock_wait  = rand_between(1, 20);
				done_wait  = 0;
				align_wait = 0;
			end else if (lock_wait > 1) begin
				lock_wait = lock_wait - 1;
			end else if (lock_wait == 1) begin
				gt_status.cpll_lock <= 1'b1;
				if (!hold_qpll) begin
					gt_status.qpll_lock <= 1'b1;
					lock_wait = 0;
				end
			end
			if (gt_ctrl.txrx_reset) begin
				gt_status.tx_reset_done <= 1'b0;
				gt_status.rx_reset_done <= 1'b0;
				gt_status.byte_aligned  <= 1'b0;
				done_wait = rand_between(1, 20);
			end else if (done_wait > 1) begin
				done_wait = done_wait - 1;
			end else if (done_wait == 1) begin
				gt_status.tx_reset_done <= 1'b1;
				gt_status.rx_reset_done <= 1'b1;
				done_wait = 0;
			end
			if (win_q && !win_d) begin
				align_wait = rand_between(1, 20); // window just opened
			end else if (align_wait > 1) begin
				align_wait = align_wait - 1;
			end else if (align_wait == 1) begin
				gt_status.byte_aligned <= 1'b1;
				align_wait = 0;
			end
			win_d = win_q;
		end
	end

	initial begin : payload_gen
		tx_payload = '0;
		forever begin
			@(posedge clk200);
			tx_payload <= $random(seed);
		end
	end

	initial begin : main_seq
		int round;
		rst_n      = 1'b0;
		soft_reset = 1'b0;
		sfp_los    = 1'b0;
		hold_qpll  = 1'b0;
		repeat (4) @(posedge clk200);
		@(negedge clk200);
		check_value("gt_ctrl after reset", 32'(gt_ctrl), 32'd0);
		check_value("link_up after reset", 32'(link_up), 32'd0);
		check_value("tx_data after reset", tx_data, COMMA_WORD);
		check_value("tx_charisk after reset", 32'(tx_charisk), 32'(COMMA_K));
		@(posedge clk200);
		rst_n <= 1'b1; // fifth reset edge
		measure_pulse(SIG_PLL, POR_DELAY + 20, "pll_reset after power-on");
		complete_bringup();
		for (round = 0; round < 6; round = round + 1) begin
			repeat (rand_between(5, 30)) @(posedge clk200);
			if (rand_between(0, 1) == 0) begin
				strobe_soft_reset();
			end else begin
				drop_los(rand_between(2, 10));
			end
			wait_level(SIG_LINK, 1'b0, 20, "link_up to drop");
			measure_pulse(SIG_PLL, 30, "pll_reset after request");
			complete_bringup();
		end
		// qpll lock withheld, chain must stall after the pll stage
		@(posedge clk200);
		hold_qpll <= 1'b1;
		strobe_soft_reset();
		wait_level(SIG_LINK, 1'b0, 20, "link_up to drop");
		measure_pulse(SIG_PLL, 30, "pll_reset with qpll held");
		repeat (40) begin
			@(negedge clk200);
			check_value("txrx_reset without qpll_lock", 32'(gt_ctrl.txrx_reset), 32'd0);
			check_value("link_up without qpll_lock", 32'(link_up), 32'd0);
		end
		@(posedge clk200);
		hold_qpll <= 1'b0;
		complete_bringup();
		repeat (10) @(posedge clk200);
		$display("Test passed");
		$finish;
	end

endmodule

//--- hdl/gt_bringup_pkg.sv
package gt_bringup_pkg;

	// transceiver data path
	typedef logic [31:0] word32_t; // one 4-byte tx word
	typedef logic [3:0]  charisk_t; // k-char flag per byte

	// status coming back from the transceiver and clocking
	typedef struct packed {
		logic mmcm_locked; // system clock mmcm
		logic qpll_lock; // quad pll
		logic qpll_refclk_lost;
		logic cpll_lock; // channel pll
		logic cpll_fbclk_lost;
		logic cpll_refclk_lost;
		logic tx_reset_done;
		logic rx_reset_done;
		logic byte_aligned; // rx comma alignment reached
	} gt_status_t;

	// reset lines toward the transceiver
	typedef struct packed {
		logic pll_reset; // qpll and cpll
		logic txrx_reset; // gttx, gtrx and rx pma
	} gt_ctrl_t;

	// one reset stage of the bring-up chain
	typedef enum logic [1:0] {
		STAGE_IDLE,
		STAGE_WAIT_READY,
		STAGE_RESET,
		STAGE_WAIT_DONE
	} stage_state_t;

	// K28.5 in the low byte, rest zero
	localparam word32_t  COMMA_WORD = 32'h0000_00bc;
	localparam charisk_t COMMA_K    = 4'b0001; // byte 0 is a control char

endpackage

//--- hdl/gt_bringup_top.sv
`timescale 1ns/1ps

module gt_bringup_top
	import gt_bringup_pkg::*;
#(
	parameter int POR_DELAY = 100, // power-on pulse delay after rst_n
	parameter int RESET_LEN = 10 // per-stage reset pulse length
) (
	input  logic       clk200,
	input  logic       rst_n,
	input  logic       soft_reset, // one-cycle strobe
	input  logic       sfp_los, // async level from optical module
	input  gt_status_t gt_status,
	input  word32_t    tx_payload,
	output gt_ctrl_t   gt_ctrl,
	output word32_t    tx_data,
	output charisk_t   tx_charisk,
	output logic       link_up
);

	logic hw_reset; // merged reset request pulse
	logic align_window;

	reset_request #(.POR_DELAY(POR_DELAY)) u_reset_request (
		.clk200     (clk200),
		.rst_n      (rst_n),
		.soft_reset (soft_reset),
		.sfp_los    (sfp_los),
		.hw_reset   (hw_reset)
	);

	gt_reset_chain #(.RESET_LEN(RESET_LEN)) u_reset_chain (
		.clk200       (clk200),
		.rst_n        (rst_n),
		.hw_reset     (hw_reset),
		.gt_status    (gt_status),
		.gt_ctrl      (gt_ctrl),
		.align_window (align_window),
		.link_up      (link_up)
	);

	tx_word_mux u_tx_word_mux (
		.clk200       (clk200),
		.rst_n        (rst_n),
		.byte_aligned (gt_status.byte_aligned), // straight from the transceiver
		.align_window (align_window),
		.tx_payload   (tx_payload),
		.tx_data      (tx_data),
		.tx_charisk   (tx_charisk)
	);

endmodule

//--- hdl/gt_reset_chain.sv
`timescale 1ns/1ps

module gt_reset_chain
	import gt_bringup_pkg::*;
#(
	parameter int RESET_LEN = 10 // pulse length for every stage
) (
	input  logic       clk200,
	input  logic       rst_n,
	input  logic       hw_reset, // one-cycle request, kicks off the chain
	input  gt_status_t gt_status,
	output gt_ctrl_t   gt_ctrl,
	output logic       align_window, // tx may send payload while high
	output logic       link_up
);

	logic plls_ready; // all plls locked and no clock lost
	logic chan_done_raw; // tx and rx reset done with plls good
	logic txrx_done; // same, gated by the delayed second-pass flag
	logic second_pass;
	logic second_pass_d;
	logic pll_rst;
	logic pll_done;
	logic chan_rst0;
	logic chan_rst1;
	logic chan_done0;
	logic chan_done1;
	logic align_done;

	assign plls_ready = &{gt_status.mmcm_locked, gt_status.qpll_lock, ~gt_status.qpll_refclk_lost,
		gt_status.cpll_lock, ~gt_status.cpll_fbclk_lost, ~gt_status.cpll_refclk_lost};
	assign chan_done_raw = gt_status.tx_reset_done & gt_status.rx_reset_done & plls_ready;
	assign txrx_done = chan_done_raw & second_pass_d;

	// second channel reset only after the channel came up once
	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			second_pass   <= 1'b0;
			second_pass_d <= 1'b0;
		end else begin
			if (hw_reset) begin
				second_pass <= 1'b0; // new bring-up
			end else if (chan_done_raw) begin
				second_pass <= 1'b1;
			end
			second_pass_d <= second_pass;
		end
	end

	gt_reset_stage #(.RESET_LEN(RESET_LEN)) pll_stage (
		.clk200        (clk200),
		.rst_n         (rst_n),
		.start         (hw_reset),
		.ready         (gt_status.mmcm_locked),
		.done_criteria (plls_ready),
		.reset_out     (pll_rst),
		.done_strobe   (pll_done)
	);

	gt_reset_stage #(.RESET_LEN(RESET_LEN)) chan_stage0 (
		.clk200        (clk200),
		.rst_n         (rst_n),
		.start         (pll_done),
		.ready         (plls_ready),
		.done_criteria (txrx_done),
		.reset_out     (chan_rst0),
		.done_strobe   (chan_done0)
	);

	gt_reset_stage #(.RESET_LEN(RESET_LEN)) chan_stage1 (
		.clk200        (clk200),
		.rst_n         (rst_n),
		.start         (chan_done0),
		.ready         (plls_ready & second_pass), // channel must have come up once
		.done_criteria (txrx_done),
		.reset_out     (chan_rst1),
		.done_strobe   (chan_done1)
	);

	gt_reset_stage #(.RESET_LEN(RESET_LEN)) align_stage (
		.clk200        (clk200),
		.rst_n         (rst_n),
		.start         (chan_done1),
		.ready         (txrx_done),
		.done_criteria (gt_status.byte_aligned),
		.reset_out     (align_window), // reset pulse doubles as payload window
		.done_strobe   (align_done)
	);

	assign gt_ctrl = '{pll_reset: pll_rst, txrx_reset: chan_rst0 | chan_rst1};

	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			link_up <= 1'b0;
		end else if (hw_reset) begin
			link_up <= 1'b0; // hw request drops the link at once
		end else if (align_done) begin
			link_up <= 1'b1;
		end
	end

endmodule

//--- hdl/gt_reset_stage.sv
`timescale 1ns/1ps

module gt_reset_stage
	import gt_bringup_pkg::*;
#(
	parameter int RESET_LEN = 10 // cycles reset_out stays high
) (
	input  logic clk200,
	input  logic rst_n,
	input  logic start, // restarts the stage from any state
	input  logic ready, // precondition before reset is applied
	input  logic done_criteria, // completion condition after reset
	output logic reset_out,
	output logic done_strobe // one cycle at end of stage
);

	localparam int CNT_W = $clog2(RESET_LEN + 1);

	stage_state_t state;
	logic [CNT_W-1:0] pulse_cnt; // cycles spent in STAGE_RESET
	logic pulse_last;

	assign pulse_last = (pulse_cnt == CNT_W'(RESET_LEN - 1));

	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			state       <= STAGE_IDLE;
			pulse_cnt   <= '0;
			done_strobe <= 1'b0;
		end else begin
			done_strobe <= 1'b0; // default low, pulses below
			if (start) begin
				state     <= STAGE_WAIT_READY; // start wins over everything
				pulse_cnt <= '0;
			end else begin
				case (state)
					STAGE_WAIT_READY: begin
						pulse_cnt <= '0;
						if (ready) begin
							state <= STAGE_RESET;
						end
					end
					STAGE_RESET: begin
						if (pulse_last) begin
							state <= STAGE_WAIT_DONE; // pulse complete
						end else begin
							pulse_cnt <= pulse_cnt + 1'b1;
						end
					end
					STAGE_WAIT_DONE: begin
						// ready may drop here, keep waiting regardless
						if (done_criteria) begin
							state       <= STAGE_IDLE;
							done_strobe <= 1'b1;
						end
					end
					default: begin
						state <= STAGE_IDLE; // idle until next start
					end
				endcase
			end
		end
	end

	assign reset_out = (state == STAGE_RESET);

endmodule

//--- hdl/reset_request.sv
`timescale 1ns/1ps

module reset_request #(
	parameter int POR_DELAY = 100 // cycles from rst_n release to power-on pulse
) (
	input  logic clk200,
	input  logic rst_n,
	input  logic soft_reset, // one-cycle strobe
	input  logic sfp_los, // async, high while optical signal is lost
	output logic hw_reset // one-cycle merged request
);

	localparam int POR_W = $clog2(POR_DELAY + 1);

	logic [POR_W-1:0] por_cnt; // saturates at POR_DELAY
	logic por_req;
	logic los_meta; // first sync flop
	logic los_sync; // second sync flop
	logic los_sync_d; // previous synchronized sample
	logic reconnect;

	// power-on counter, stops once it reaches the end so the pulse is single
	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			por_cnt <= '0;
		end else if (por_cnt != POR_W'(POR_DELAY)) begin
			por_cnt <= por_cnt + 1'b1;
		end
	end

	assign por_req = (por_cnt == POR_W'(POR_DELAY - 1)); // true for one cycle only

	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			los_meta   <= 1'b0; // low so a dark fiber at start is not a reconnect
			los_sync   <= 1'b0;
			los_sync_d <= 1'b0;
		end else begin
			los_meta   <= sfp_los;
			los_sync   <= los_meta;
			los_sync_d <= los_sync;
		end
	end

	assign reconnect = ~los_sync & los_sync_d; // los went high to low

	// merge the three requests
	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			hw_reset <= 1'b0;
		end else begin
			hw_reset <= por_req | soft_reset | reconnect;
		end
	end

endmodule

//--- hdl/tx_word_mux.sv
`timescale 1ns/1ps

module tx_word_mux
	import gt_bringup_pkg::*;
(
	input  logic     clk200,
	input  logic     rst_n,
	input  logic     byte_aligned, // far end locked onto our commas
	input  logic     align_window, // from alignment stage
	input  word32_t  tx_payload,
	output word32_t  tx_data,
	output charisk_t tx_charisk
);

	logic send_payload;

	assign send_payload = byte_aligned | align_window;

	always_ff @(posedge clk200) begin
		if (!rst_n) begin
			tx_data    <= COMMA_WORD; // commas until the link aligns
			tx_charisk <= COMMA_K;
		end else if (send_payload) begin
			tx_data    <= tx_payload;
			tx_charisk <= '0; // payload is all data chars
		end else begin
			tx_data    <= COMMA_WORD;
			tx_charisk <= COMMA_K;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the bring-up testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module gt_bringup_tb -o gt_bringup_sim \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/gt_bringup_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
